//--- hdl/dct_pkg.sv
package dct_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Block geometry.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int BLK_DIM  = 8;
  localparam int NUM_COEF = BLK_DIM * BLK_DIM;
  localparam int POS_W    = 3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath widths.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int PIX_W   = 8;
  localparam int COS_W   = 12;   // Holds +/-1024.
  localparam int PHASE_W = 5;    // 32 steps of pi/16.
  localparam int ACC_W   = 36;
  localparam int COEF_W  = 16;

  localparam int SCALE_SHIFT = 30;  // Two 2^10 cosines plus alpha scale.

  // Normalisation, 1/sqrt(2) terms scaled by 256.
  localparam logic [10:0] ALPHA_DC   = 11'd128;
  localparam logic [10:0] ALPHA_EDGE = 11'd181;
  localparam logic [10:0] ALPHA_AC   = 11'd256;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic        [POS_W-1:0]   pos_t;
  typedef logic signed [PIX_W-1:0]   pixel_t;
  typedef logic signed [COS_W-1:0]   cos_t;
  typedef logic        [PHASE_W-1:0] phase_t;
  typedef logic signed [COEF_W-1:0]  coef_t;

  // One input sample tagged with its raster position.
  typedef struct packed {
    pos_t   x;
    pos_t   y;
    pixel_t pixel;
  } sample_t;

  // All coefficients of a block, index v*8+u.
  typedef coef_t [NUM_COEF-1:0] coef_vec_t;

endpackage

//--- hdl/cosine_rom.sv
`timescale 1ns/100ps

module cosine_rom (
  input  dct_pkg::phase_t phase,
  output dct_pkg::cos_t   amp
);

  import dct_pkg::*;

  // 1024*cos(k*pi/16), truncated toward zero.
  always_comb begin
    case (phase)
      5'd0:    amp = 12'sd1024;
      5'd1:    amp = 12'sd1004;
      5'd2:    amp = 12'sd946;
      5'd3:    amp = 12'sd851;
      5'd4:    amp = 12'sd724;
      5'd5:    amp = 12'sd568;
      5'd6:    amp = 12'sd391;
      5'd7:    amp = 12'sd199;
      5'd8:    amp = 12'sd0;
      5'd9:    amp = -12'sd199;
      5'd10:   amp = -12'sd391;
      5'd11:   amp = -12'sd568;
      5'd12:   amp = -12'sd724;
      5'd13:   amp = -12'sd851;
      5'd14:   amp = -12'sd946;
      5'd15:   amp = -12'sd1004;
      // Second half of the period.
      5'd16:   amp = -12'sd1024;
      5'd17:   amp = -12'sd1004;
      5'd18:   amp = -12'sd946;
      5'd19:   amp = -12'sd851;
      5'd20:   amp = -12'sd724;
      5'd21:   amp = -12'sd568;
      5'd22:   amp = -12'sd391;
      5'd23:   amp = -12'sd199;
      5'd24:   amp = 12'sd0;
      5'd25:   amp = 12'sd199;
      5'd26:   amp = 12'sd391;
      5'd27:   amp = 12'sd568;
      5'd28:   amp = 12'sd724;
      5'd29:   amp = 12'sd851;
      5'd30:   amp = 12'sd946;
      5'd31:   amp = 12'sd1004;
      default: amp = '0;
    endcase
  end

endmodule

//--- hdl/coef_accumulator.sv
`timescale 1ns/100ps

module coef_accumulator #(
  parameter int U_IDX = 0,
  parameter int V_IDX = 0
) (
  input  logic              s00_axis_aclk,
  input  logic              rst_in,
  input  dct_pkg::sample_t  sample,
  input  logic              sample_en,
  input  logic              capture,
  output dct_pkg::coef_t    coef
);

  import dct_pkg::*;

  localparam logic [10:0] ALPHA = (U_IDX == 0 && V_IDX == 0) ? ALPHA_DC :
                                  (U_IDX != 0 && V_IDX != 0) ? ALPHA_AC : ALPHA_EDGE;
  localparam int PROD_W = ACC_W + $bits(ALPHA) + 1;

  phase_t x_phase;
  phase_t y_phase;
  cos_t   x_amp;
  cos_t   y_amp;

  logic signed [ACC_W-1:0]  term;
  logic signed [ACC_W-1:0]  sum;
  logic signed [PROD_W-1:0] scaled_prod;
  logic signed [PROD_W-1:0] shifted;

  // ((2n+1)*k) mod 32, low bits only.
  assign x_phase = phase_t'({sample.x, 1'b1} * U_IDX);
  assign y_phase = phase_t'({sample.y, 1'b1} * V_IDX);

  cosine_rom i_cos_x (
    .phase (x_phase),
    .amp   (x_amp)
  );

  cosine_rom i_cos_y (
    .phase (y_phase),
    .amp   (y_amp)
  );

  assign term = x_amp * y_amp * sample.pixel;

  assign scaled_prod = sum * $signed({1'b0, ALPHA});
  assign shifted     = scaled_prod >>> SCALE_SHIFT;

  always_ff @(posedge s00_axis_aclk) begin
    if (rst_in) begin
      sum <= '0;
    end else if (capture) begin
      sum <= '0;                // Ready for the next block.
    end else if (sample_en) begin
      sum <= sum + term;
    end
  end

  always_ff @(posedge s00_axis_aclk) begin
    if (capture) begin
      coef <= shifted[COEF_W-1:0];
    end
  end

  // Upper bits must be pure sign extension.
  a_coef_fits: assert property (@(posedge s00_axis_aclk) disable iff (rst_in)
    capture |-> ((&shifted[PROD_W-1:COEF_W-1]) || !(|shifted[PROD_W-1:COEF_W-1])));

endmodule

//--- hdl/dct_sequencer.sv
`timescale 1ns/100ps

module dct_sequencer (
  input  logic              s00_axis_aclk,
  input  logic              rst_in,

  input  logic              s00_axis_tvalid,
  output logic              s00_axis_tready,
  input  dct_pkg::pixel_t   s00_axis_tdata,
  input  logic              s00_axis_tlast,

  output dct_pkg::sample_t  sample,
  output logic              sample_en,
  output logic              capture,

  input  logic              drain_busy
);

  import dct_pkg::*;

  localparam pos_t LAST_POS = pos_t'(BLK_DIM - 1);

  typedef enum logic [1:0] {
    S_ACCEPT,
    S_WAIT_DRAIN,
    S_CAPTURE
  } seq_state_t;

  seq_state_t state;
  seq_state_t state_n;

  pos_t x_pos;
  pos_t y_pos;
  logic handshake;
  logic block_end;

  assign handshake = s00_axis_tvalid && s00_axis_tready;
  assign block_end = handshake && (x_pos == LAST_POS) && (y_pos == LAST_POS);

  assign sample    = '{x: x_pos, y: y_pos, pixel: s00_axis_tdata};
  assign sample_en = handshake;
  assign capture   = (state == S_CAPTURE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Block FSM.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_n = state;
    case (state)
      S_ACCEPT: begin
        if (block_end) begin
          // Coefficient registers still in use by the drain.
          state_n = drain_busy ? S_WAIT_DRAIN : S_CAPTURE;
        end
      end
      S_WAIT_DRAIN: begin
        if (!drain_busy) begin
          state_n = S_CAPTURE;
        end
      end
      S_CAPTURE: state_n = S_ACCEPT;
      default:   state_n = S_ACCEPT;
    endcase
  end

  always_ff @(posedge s00_axis_aclk) begin
    if (rst_in) begin
      state           <= S_ACCEPT;
      s00_axis_tready <= 1'b0;
    end else begin
      state           <= state_n;
      s00_axis_tready <= (state_n == S_ACCEPT);  // Closed until sums are captured.
    end
  end

  // Raster position, x fastest.
  always_ff @(posedge s00_axis_aclk) begin
    if (rst_in) begin
      x_pos <= '0;
      y_pos <= '0;
    end else if (handshake) begin
      x_pos <= x_pos + 1'b1;
      if (x_pos == LAST_POS) begin
        y_pos <= y_pos + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_tlast_on_last: assert property (@(posedge s00_axis_aclk) disable iff (rst_in)
    handshake |-> (s00_axis_tlast == ((x_pos == LAST_POS) && (y_pos == LAST_POS))));

  a_capture_idle: assert property (@(posedge s00_axis_aclk) disable iff (rst_in)
    capture |-> !drain_busy);

endmodule

//--- hdl/coef_drain.sv
`timescale 1ns/100ps

module coef_drain (
  input  logic               s00_axis_aclk,
  input  logic               rst_in,

  input  dct_pkg::coef_vec_t coefs,
  input  logic               capture,

  output logic               m00_axis_tvalid,
  input  logic               m00_axis_tready,
  output dct_pkg::coef_t     m00_axis_tdata,
  output logic               m00_axis_tlast,

  output logic               drain_busy
);

  import dct_pkg::*;

  localparam int IDX_W = $clog2(NUM_COEF);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_COEF - 1);

  logic [IDX_W-1:0] rd_idx;
  logic             beat;

  assign beat = m00_axis_tvalid && m00_axis_tready;

  // Coefficient registers hold still while busy.
  assign m00_axis_tvalid = drain_busy;
  assign m00_axis_tdata  = coefs[rd_idx];
  assign m00_axis_tlast  = drain_busy && (rd_idx == LAST_IDX);

  always_ff @(posedge s00_axis_aclk) begin
    if (rst_in) begin
      drain_busy <= 1'b0;
      rd_idx     <= '0;
    end else if (capture) begin
      drain_busy <= 1'b1;
      rd_idx     <= '0;
    end else if (beat) begin
      rd_idx <= rd_idx + 1'b1;   // Wraps to 0 after the last.
      if (rd_idx == LAST_IDX) begin
        drain_busy <= 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stream rule.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_hold_stalled: assert property (@(posedge s00_axis_aclk) disable iff (rst_in)
    (m00_axis_tvalid && !m00_axis_tready) |=>
      (m00_axis_tvalid && $stable(m00_axis_tdata)));

endmodule

//--- hdl/dct_block.sv
`timescale 1ns/100ps

module dct_block (
  input  logic             s00_axis_aclk,
  input  logic             rst_in,

  // Pixel stream in.
  input  logic             s00_axis_tvalid,
  output logic             s00_axis_tready,
  input  dct_pkg::pixel_t  s00_axis_tdata,
  input  logic             s00_axis_tlast,

  // Coefficient stream out.
  output logic             m00_axis_tvalid,
  input  logic             m00_axis_tready,
  output dct_pkg::coef_t   m00_axis_tdata,
  output logic             m00_axis_tlast
);

  import dct_pkg::*;

  sample_t   sample;
  logic      sample_en;
  logic      capture;
  logic      drain_busy;
  coef_vec_t coefs;

  dct_sequencer i_sequencer (
    .s00_axis_aclk   (s00_axis_aclk),
    .rst_in          (rst_in),
    .s00_axis_tvalid (s00_axis_tvalid),
    .s00_axis_tready (s00_axis_tready),
    .s00_axis_tdata  (s00_axis_tdata),
    .s00_axis_tlast  (s00_axis_tlast),
    .sample          (sample),
    .sample_en       (sample_en),
    .capture         (capture),
    .drain_busy      (drain_busy)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One accumulator per (u, v).
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar v = 0; v < BLK_DIM; v++) begin : g_row
    for (genvar u = 0; u < BLK_DIM; u++) begin : g_col
      coef_accumulator #(
        .U_IDX (u),
        .V_IDX (v)
      ) i_acc (
        .s00_axis_aclk (s00_axis_aclk),
        .rst_in        (rst_in),
        .sample        (sample),
        .sample_en     (sample_en),
        .capture       (capture),
        .coef          (coefs[v*BLK_DIM+u])
      );
    end
  end

  coef_drain i_drain (
    .s00_axis_aclk   (s00_axis_aclk),
    .rst_in          (rst_in),
    .coefs           (coefs),
    .capture         (capture),
    .m00_axis_tvalid (m00_axis_tvalid),
    .m00_axis_tready (m00_axis_tready),
    .m00_axis_tdata  (m00_axis_tdata),
    .m00_axis_tlast  (m00_axis_tlast),
    .drain_busy      (drain_busy)
  );

endmodule

//--- sim/dct_model.svh
`ifndef DCT_MODEL_SVH
`define DCT_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference DCT model, one block at a time.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam real MODEL_PI = 3.141592653589793;

int cos_tab [32];     // 1024*cos(k*pi/16), truncated toward zero.
int blk_pix [64];     // Current block, raster order, x fastest.
int exp_q   [$];      // Expected coefficients in output order.

function automatic void build_cos_table();
  real amp;
  for (int k = 0; k < 32; k++) begin
    amp = 1024.0 * $cos(k * MODEL_PI / 16.0);
    // Small guard so exact values survive rounding noise.
    if (amp >= 0.0) begin
      cos_tab[k] = $rtoi(amp + 1.0e-9);
    end else begin
      cos_tab[k] = $rtoi(amp - 1.0e-9);
    end
  end
endfunction

// Appends the 64 coefficients of blk_pix to exp_q, order v*8+u.
function automatic void model_block();
  longint acc;
  longint alpha;
  longint scaled;
  for (int v = 0; v < 8; v++) begin
    for (int u = 0; u < 8; u++) begin
      acc = 0;
      for (int y = 0; y < 8; y++) begin
        for (int x = 0; x < 8; x++) begin
          acc += longint'(cos_tab[((2*x+1)*u) % 32]) *
                 longint'(cos_tab[((2*y+1)*v) % 32]) * longint'(blk_pix[y*8+x]);
        end
      end
      if (u == 0 && v == 0) alpha = 128;
      else if (u != 0 && v != 0) alpha = 256;
      else alpha = 181;
      scaled = (acc * alpha) >>> 30;
      exp_q.push_back(int'(scaled));
    end
  end
endfunction

`endif

//--- sim/dct_block_tb.sv
`timescale 1ns/100ps

module dct_block_tb;

  import dct_pkg::*;

  localparam int          CLK_HALF    = 50;
  localparam logic [31:0] SEED        = 32'hfc8ca126;
  localparam int          NUM_BLOCKS  = 14;                     // 1 + 3 + 2 + 8.
  localparam int          CYCLE_LIMIT = 400 * NUM_BLOCKS + 100;

  logic   s00_axis_aclk;
  logic   rst_in;
  logic   s00_axis_tvalid;
  logic   s00_axis_tready;
  pixel_t s00_axis_tdata;
  logic   s00_axis_tlast;
  logic   m00_axis_tvalid;
  logic   m00_axis_tready;
  coef_t  m00_axis_tdata;
  logic   m00_axis_tlast;

  logic [31:0] pix_state;
  logic [31:0] rdy_state;
  logic        out_stalls;
  logic        saw_wait;
  string       test_name;
  int          value_errs;
  int          other_errs;
  int          out_count;
  int          blk_beat;
  int          cycles;
  int          low_run;
  int          last_blk [64];

  `include "dct_model.svh"

  dct_block i_dct_block (
    .s00_axis_aclk   (s00_axis_aclk),
    .rst_in          (rst_in),
    .s00_axis_tvalid (s00_axis_tvalid),
    .s00_axis_tready (s00_axis_tready),
    .s00_axis_tdata  (s00_axis_tdata),
    .s00_axis_tlast  (s00_axis_tlast),
    .m00_axis_tvalid (m00_axis_tvalid),
    .m00_axis_tready (m00_axis_tready),
    .m00_axis_tdata  (m00_axis_tdata),
    .m00_axis_tlast  (m00_axis_tlast)
  );

  initial begin
    s00_axis_aclk = 1'b0;
    forever #CLK_HALF s00_axis_aclk = ~s00_axis_aclk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  function automatic logic chance(input int pct);
    pix_state = xorshift32(pix_state);
    return (pix_state % 100) < pct;
  endfunction

  function automatic int magnitude(input int a);
    return (a < 0) ? -a : a;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge s00_axis_aclk) begin
    if (out_stalls) begin
      rdy_state = xorshift32(rdy_state);
      m00_axis_tready = (rdy_state % 100) >= 30;   // About 30% drops.
    end else begin
      m00_axis_tready = 1'b1;
    end
  end

  task automatic check_output_beat();
    int exp_val;
    int act_val;
    act_val = int'(m00_axis_tdata);
    if (exp_q.size() == 0) begin
      $display("Output beat %0d came with no coefficient left to expect (%s)",
               out_count, test_name);
      other_errs++;
    end else begin
      exp_val = exp_q.pop_front();
      if (act_val != exp_val) begin
        $display("ERR %s expected %0d actual %0d (coefficient %0d)",
                 test_name, exp_val, act_val, blk_beat);
        value_errs++;
      end
    end
    if (m00_axis_tlast != (blk_beat == NUM_COEF - 1)) begin
      $display("ERR %s expected %0d actual %0d (tlast, coefficient %0d)",
               test_name, (blk_beat == NUM_COEF - 1), m00_axis_tlast, blk_beat);
      value_errs++;
    end
    last_blk[blk_beat] = act_val;
    out_count++;
    blk_beat = (blk_beat + 1) % NUM_COEF;
  endtask

  always @(posedge s00_axis_aclk) begin
    if (!rst_in) begin
      if (m00_axis_tvalid && m00_axis_tready) begin
        check_output_beat();
      end
      // Longer than the capture cycle means a block waits on the drain.
      if (s00_axis_tvalid && !s00_axis_tready) begin
        low_run++;
        if (low_run >= 2) saw_wait = 1'b1;
      end else begin
        low_run = 0;
      end
    end
  end

  task automatic print_counts();
    $display("Errors: %0d value, %0d other; %0d outputs checked",
             value_errs, other_errs, out_count);
  endtask

  always @(posedge s00_axis_aclk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles in %s, outputs never completed",
               cycles, test_name);
      other_errs++;
      print_counts();
      $display("Test FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input side.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic fill_random();
    for (int i = 0; i < NUM_COEF; i++) begin
      pix_state = xorshift32(pix_state);
      blk_pix[i] = int'($signed(pix_state[7:0]));
    end
  endtask

  task automatic fill_const(input int val);
    for (int i = 0; i < NUM_COEF; i++) begin
      blk_pix[i] = val;
    end
  endtask

  task automatic send_block(input logic use_gaps);
    int   idx;
    logic holding;
    idx = 0;
    holding = 1'b0;
    model_block();
    while (idx < NUM_COEF) begin
      @(negedge s00_axis_aclk);
      if (!holding) begin
        if (use_gaps && chance(25)) begin
          s00_axis_tvalid = 1'b0;
          s00_axis_tlast  = 1'b0;
        end else begin
          s00_axis_tvalid = 1'b1;
          s00_axis_tdata  = pixel_t'(blk_pix[idx]);
          s00_axis_tlast  = (idx == NUM_COEF - 1);
          holding = 1'b1;
        end
      end
      @(posedge s00_axis_aclk);
      if (s00_axis_tvalid && s00_axis_tready) begin
        idx++;
        holding = 1'b0;
      end
    end
  endtask

  task automatic stop_input();
    @(negedge s00_axis_aclk);
    s00_axis_tvalid = 1'b0;
    s00_axis_tlast  = 1'b0;
  endtask

  task automatic wait_outputs(input int target);
    while (out_count < target) begin
      @(posedge s00_axis_aclk);
    end
  endtask

  task automatic check_dc_largest();
    for (int k = 1; k < NUM_COEF; k++) begin
      if (magnitude(last_blk[k]) > magnitude(last_blk[0])) begin
        $display("Coefficient %0d (%0d) is larger than the DC term (%0d) in %s",
                 k, last_blk[k], last_blk[0], test_name);
        other_errs++;
      end
    end
  endtask

  task automatic reset_dut();
    rst_in = 1'b1;
    repeat (4) @(posedge s00_axis_aclk);
    @(negedge s00_axis_aclk);
    if (m00_axis_tvalid || m00_axis_tlast || s00_axis_tready) begin
      $display("Stream outputs are not low during reset");
      other_errs++;
    end
    rst_in = 1'b0;
    for (int i = 0; i < 2; i++) begin
      @(negedge s00_axis_aclk);
      if (s00_axis_tready) break;
    end
    if (!s00_axis_tready) begin
      $display("Input tready did not rise within 2 cycles of reset release");
      other_errs++;
    end
    if (m00_axis_tvalid || m00_axis_tlast) begin
      $display("Output tvalid or tlast is high after reset");
      other_errs++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int base;
    int const_vals [3];
    rst_in          = 1'b1;
    s00_axis_tvalid = 1'b0;
    s00_axis_tdata  = '0;
    s00_axis_tlast  = 1'b0;
    m00_axis_tready = 1'b1;
    pix_state  = SEED;
    rdy_state  = SEED ^ 32'h5a5a5a5a;     // Own stream for output stalls.
    out_stalls = 1'b0;
    saw_wait   = 1'b0;
    value_errs = 0;
    other_errs = 0;
    out_count  = 0;
    blk_beat   = 0;
    cycles     = 0;
    low_run    = 0;
    const_vals = '{0, 127, -128};
    build_cos_table();

    test_name = "reset";
    reset_dut();

    test_name = "single_random";
    fill_random();
    send_block(1'b0);
    stop_input();
    wait_outputs(NUM_COEF);

    test_name = "constant";
    for (int c = 0; c < 3; c++) begin
      base = out_count;
      fill_const(const_vals[c]);
      send_block(1'b0);
      stop_input();
      wait_outputs(base + NUM_COEF);
      check_dc_largest();
    end

    test_name = "gaps_stalls";
    base = out_count;
    out_stalls = 1'b1;
    for (int b = 0; b < 2; b++) begin
      fill_random();
      send_block(1'b1);
    end
    stop_input();
    wait_outputs(base + 2 * NUM_COEF);

    test_name = "back_to_back";
    base = out_count;
    saw_wait = 1'b0;
    for (int b = 0; b < 8; b++) begin
      fill_random();
      send_block(1'b0);
    end
    stop_input();
    wait_outputs(base + 8 * NUM_COEF);
    repeat (20) @(posedge s00_axis_aclk);  // Catch stray extra beats.
    out_stalls = 1'b0;
    if (out_count - base != 8 * NUM_COEF) begin
      $display("Eight blocks gave %0d outputs instead of 512", out_count - base);
      other_errs++;
    end
    if (!saw_wait) begin
      $display("Input tready never held off a full block waiting for capture");
      other_errs++;
    end

    if (exp_q.size() != 0) begin
      $display("%0d expected coefficients never came out", exp_q.size());
      other_errs++;
    end
    print_counts();
    if (value_errs + other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- dct_block.f
+incdir+sim
hdl/dct_pkg.sv
hdl/cosine_rom.sv
hdl/coef_accumulator.sv
hdl/dct_sequencer.sv
hdl/coef_drain.sv
hdl/dct_block.sv
sim/dct_block_tb.sv
